/* Bender.yml */
package:
  name: rob_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rob_pkg.sv
      - verilog/dispatch_port.sv
      - verilog/rob_buffer.sv
      - verilog/reg_status.sv
      - verilog/rob_core_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/rob_monitor.sv
      - sim/rob_checker.sv
      - sim/rob_tb.sv

/* sim/rob_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_checker
    import rob_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    disp_req,
    input  logic    disp_ack,
    input  logic    alloc_ready,
    input  logic    flush,
    input  commit_t commit_out
);

    int                fails = 0;
    logic              seen;
    logic [`TAG_W-1:0] last_tag;

    function automatic logic [`TAG_W-1:0] after(input logic [`TAG_W-1:0] t);
        return `TAG_W'(int'(t) % `ROB_DEPTH + 1);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            seen     <= 1'b0;
            last_tag <= '0;
        end else if (commit_out.valid) begin
            seen     <= 1'b1;
            last_tag <= commit_out.tag;
        end
    end

    ack_held: assert property (@(posedge clk) disable iff (rst)
        $fell(disp_ack) |-> !disp_req)
        else begin
            fails++;
            $error("disp_ack fell while disp_req was high");
        end

    // the flush comes with its commit, and nothing was allocated at that edge
    no_alloc_in_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> commit_out.valid && !$past(alloc_ready))
        else begin
            fails++;
            $error("flush without its commit or alloc_ready high at the redirecting commit");
        end

    // a redirect moves head to the retired tag plus one, so order still holds
    commit_order: assert property (@(posedge clk) disable iff (rst)
        (commit_out.valid && seen) |-> commit_out.tag == after(last_tag))
        else begin
            fails++;
            $error("commit tag did not advance by one");
        end

endmodule

bind rob_core_top rob_checker chk (
    .clk         (clk),
    .rst         (rst),
    .disp_req    (disp_req),
    .disp_ack    (disp_ack),
    .alloc_ready (alloc_ready),
    .flush       (flush),
    .commit_out  (commit_out)
);

`default_nettype wire

/* sim/rob_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_monitor
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [`TAG_W-1:0] disp_tag,
    input  operand_t          q_op1,
    input  operand_t          q_op2,
    input  commit_t           commit_out,
    input  redirect_t         redirect
);

    typedef struct packed {
        logic [2:0]         op;
        logic [`REG_W-1:0]  dest;
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] value;
        logic               redir;
        logic [`DATA_W-1:0] pc;
    } exp_commit_t;

    exp_commit_t exp_q [$];
    int errors      = 0;
    int test_errors = 0;
    int tests       = 0;

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            errors++;
            test_errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic report_fail(input string msg);
        errors++;
        test_errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic push_commit(input logic [2:0] op, input logic [`REG_W-1:0] dest,
                               input logic [`TAG_W-1:0] tag, input logic [31:0] value);
        exp_commit_t e;
        e.op    = op;
        e.dest  = dest;
        e.tag   = tag;
        e.value = value;
        e.redir = 1'b0;
        e.pc    = '0;
        exp_q.push_back(e);
    endtask

    // applies to the commit queued last
    task automatic set_redirect(input logic [31:0] pc);
        exp_commit_t e;
        e       = exp_q[exp_q.size()-1];
        e.redir = 1'b1;
        e.pc    = pc;
        exp_q[exp_q.size()-1] = e;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_tag(input logic [`TAG_W-1:0] exp);
        compare("dispatch tag", 32'(exp), 32'(disp_tag));
    endtask

    task automatic check_one(input string which, input operand_t got, input logic r,
                             input logic [31:0] v, input logic [`TAG_W-1:0] t);
        compare({which, " ready"}, 32'(r), 32'(got.ready));
        // a pending operand carries a stale value
        if (r) begin
            compare({which, " value"}, v, got.value);
        end
        compare({which, " tag"}, 32'(t), 32'(got.tag));
    endtask

    task automatic check_ops(input logic r1, input logic [31:0] v1, input logic [`TAG_W-1:0] t1,
                             input logic r2, input logic [31:0] v2, input logic [`TAG_W-1:0] t2);
        check_one("operand 1", q_op1, r1, v1, t1);
        check_one("operand 2", q_op2, r2, v2, t2);
    endtask

    task automatic end_test(input logic [31:0] n);
        tests++;
        $display("test %0d finished with %0d errors", n, test_errors);
        test_errors = 0;
    endtask

    always @(negedge clk) begin
        exp_commit_t e;
        if (!rst && commit_out.valid) begin
            if (exp_q.size() == 0) begin
                report_fail($sformatf("unexpected commit of tag %0d", commit_out.tag));
            end else begin
                e = exp_q.pop_front();
                compare("commit op", 32'(e.op), 32'(commit_out.op));
                compare("commit dest", 32'(e.dest), 32'(commit_out.dest));
                compare("commit tag", 32'(e.tag), 32'(commit_out.tag));
                compare("commit value", e.value, commit_out.value);
                compare("redirect valid", 32'(e.redir), 32'(redirect.valid));
                if (e.redir) begin
                    compare("redirect pc", e.pc, redirect.pc);
                end
            end
        end else if (!rst && redirect.valid) begin
            report_fail("redirect without a commit");
        end
    end

endmodule

`default_nettype wire

/* sim/rob_patterns.txt */
# D op dest pc pred tag | S op dest pc pred | N cycles | A tag | R bus tag value taken target
# F shuffle | C op dest tag value | P pc | Q rs1 rs2 rdy1 val1 tag1 rdy2 val2 tag2 | W | E test
D 0 01 000 0 1
D 0 02 004 0 2
D 0 03 008 0 3
D 0 04 00c 0 4
D 0 05 010 0 5
D 0 06 014 0 6
D 0 07 018 0 7
D 0 08 01c 0 8
S 0 0a 020 0
N 4
R 0 1 11 0 0
R 1 2 22 0 0
R 0 3 33 0 0
R 1 4 44 0 0
R 0 5 55 0 0
R 1 6 66 0 0
R 0 7 77 0 0
R 1 8 88 0 0
C 0 01 1 11
C 0 02 2 22
C 0 03 3 33
C 0 04 4 44
C 0 05 5 55
C 0 06 6 66
C 0 07 7 77
C 0 08 8 88
F 1
E 1
A 1
E 2
Q 0a 00 0 0 1 1 0 0
R 0 1 aa 0 0
C 0 0a 1 aa
F 0
Q 0a 00 1 aa 1 1 0 0
W
Q 0a 00 1 aa 0 1 0 0
E 3
D 3 00 100 1 2
R 0 2 0 1 200
C 3 00 2 0
D 3 00 200 1 3
D 0 0b 208 0 4
R 0 4 bb 0 0
R 0 3 0 0 0
C 3 00 3 0
P 204
F 0
D 3 00 300 0 4
D 0 0c 304 0 5
R 0 4 0 1 400
C 3 00 4 0
P 400
F 0
W
Q 0b 0c 1 0 0 1 0 0
E 4
D 2 00 500 0 5
D 4 0d 504 0 6
R 1 5 1234 0 0
R 0 6 508 0 600
C 2 00 5 1234
C 4 0d 6 508
P 600
F 1
W
Q 0d 01 1 508 0 1 11 0
E 5
D 0 00 700 0 7
R 0 7 dead 0 0
C 0 00 7 dead
F 0
Q 00 00 1 0 0 1 0 0
W
Q 00 00 1 0 0 1 0 0
E 6

/* sim/rob_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_tb
    import rob_pkg::*;
();

    localparam int LIMIT = 200;

    logic              clk;
    logic              rst;
    logic              disp_req;
    dispatch_t         disp;
    logic              disp_ack;
    logic [`TAG_W-1:0] disp_tag;
    cdb_t              alu_cdb;
    cdb_t              ls_cdb;
    logic [`REG_W-1:0] q_rs1;
    logic [`REG_W-1:0] q_rs2;
    operand_t          q_op1;
    operand_t          q_op2;
    commit_t           commit_out;
    redirect_t         redirect;

    // results waiting to be sent where bus 1 is load/store
    logic              pend_bus [$];
    cdb_t              pend_cdb [$];
    logic [31:0]       seed;
    logic              aborted;
    int                fd;
    logic [7:0]        c;
    logic [31:0]       v0;
    logic [31:0]       v1;
    logic [31:0]       v2;
    logic [31:0]       v3;
    logic [31:0]       v4;
    logic [31:0]       v5;
    logic [31:0]       v6;
    logic [31:0]       v7;

    rob_core_top dut (
        .clk        (clk),
        .rst        (rst),
        .disp_req   (disp_req),
        .disp       (disp),
        .disp_ack   (disp_ack),
        .disp_tag   (disp_tag),
        .alu_cdb    (alu_cdb),
        .ls_cdb     (ls_cdb),
        .q_rs1      (q_rs1),
        .q_rs2      (q_rs2),
        .q_op1      (q_op1),
        .q_op2      (q_op2),
        .commit_out (commit_out),
        .redirect   (redirect)
    );

    rob_monitor mon (
        .clk        (clk),
        .rst        (rst),
        .disp_tag   (disp_tag),
        .q_op1      (q_op1),
        .q_op2      (q_op2),
        .commit_out (commit_out),
        .redirect   (redirect)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stalled(input string what);
        aborted = 1'b1;
        $display("Timeout: no %s within %0d cycles", what, LIMIT);
    endtask

    task automatic dispatch_start(input logic [31:0] op, input logic [31:0] dest,
                                  input logic [31:0] pc, input logic [31:0] pred);
        @(negedge clk);
        disp.op              = rob_op_e'(op[2:0]);
        disp.dest            = dest[`REG_W-1:0];
        disp.pc              = pc;
        disp.predicted_taken = pred[0];
        disp_req             = 1'b1;
    endtask

    task automatic dispatch_finish(input logic [31:0] tag);
        int n;
        n = 0;
        while (!disp_ack && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!disp_ack) begin
            stalled("dispatch acknowledge");
            return;
        end
        mon.check_tag(tag[`TAG_W-1:0]);
        disp_req = 1'b0;
        n = 0;
        while (disp_ack && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (disp_ack) begin
            stalled("release of the dispatch acknowledge");
        end
    endtask

    task automatic no_ack(input logic [31:0] cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (disp_ack) begin
                mon.report_fail("dispatch was acknowledged while the buffer was full");
            end
        end
    endtask

    task automatic queue_result(input logic [31:0] bus, input logic [31:0] tag,
                                input logic [31:0] value, input logic [31:0] taken,
                                input logic [31:0] target);
        cdb_t r;
        r.valid  = 1'b1;
        r.tag    = tag[`TAG_W-1:0];
        r.value  = value;
        r.taken  = taken[0];
        r.target = target;
        pend_bus.push_back(bus[0]);
        pend_cdb.push_back(r);
    endtask

    task automatic send_results(input logic [31:0] shuffle);
        int   idx;
        cdb_t r;
        while (pend_cdb.size() > 0) begin
            idx = 0;
            if (shuffle[0]) begin
                seed = lcg_step(seed);
                idx  = int'(seed[31:16]) % pend_cdb.size();
            end
            @(negedge clk);
            r = pend_cdb[idx];
            if (pend_bus[idx]) begin
                ls_cdb  = r;
                alu_cdb = '0;
            end else begin
                alu_cdb = r;
                ls_cdb  = '0;
            end
            pend_cdb.delete(idx);
            pend_bus.delete(idx);
        end
        @(negedge clk);
        alu_cdb = '0;
        ls_cdb  = '0;
    endtask

    // operands are combinational and checked well before the next rising edge
    task automatic query(input logic [31:0] rs1, input logic [31:0] rs2);
        q_rs1 = rs1[`REG_W-1:0];
        q_rs2 = rs2[`REG_W-1:0];
        #5;
        mon.check_ops(v2[0], v3, v4[`TAG_W-1:0], v5[0], v6, v7[`TAG_W-1:0]);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (mon.pending() != 0 && n < LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (mon.pending() != 0) begin
            stalled("expected commit");
        end else begin
            repeat (2) @(negedge clk);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        disp_req = 1'b0;
        disp     = '0;
        alu_cdb  = '0;
        ls_cdb   = '0;
        q_rs1    = '0;
        q_rs2    = '0;
        seed     = 32'h9845_736b;
        aborted  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/rob_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file sim/rob_patterns.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted) begin
            if ($fscanf(fd, " %c", c) != 1) begin
                break;
            end
            case (c)
                "#": begin
                    while (c != 8'h0a && $fscanf(fd, "%c", c) == 1) begin
                    end
                end
                "D": begin
                    void'($fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4));
                    dispatch_start(v0, v1, v2, v3);
                    dispatch_finish(v4);
                end
                "S": begin
                    void'($fscanf(fd, "%h %h %h %h", v0, v1, v2, v3));
                    dispatch_start(v0, v1, v2, v3);
                end
                "N": begin
                    void'($fscanf(fd, "%h", v0));
                    no_ack(v0);
                end
                "A": begin
                    void'($fscanf(fd, "%h", v0));
                    dispatch_finish(v0);
                end
                "R": begin
                    void'($fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4));
                    queue_result(v0, v1, v2, v3, v4);
                end
                "F": begin
                    void'($fscanf(fd, "%h", v0));
                    send_results(v0);
                end
                "C": begin
                    void'($fscanf(fd, "%h %h %h %h", v0, v1, v2, v3));
                    mon.push_commit(v0[2:0], v1[`REG_W-1:0], v2[`TAG_W-1:0], v3);
                end
                "P": begin
                    void'($fscanf(fd, "%h", v0));
                    mon.set_redirect(v0);
                end
                "Q": begin
                    void'($fscanf(fd, "%h %h %h %h %h %h %h %h",
                                  v0, v1, v2, v3, v4, v5, v6, v7));
                    query(v0, v1);
                end
                "W": begin
                    drain();
                end
                "E": begin
                    void'($fscanf(fd, "%h", v0));
                    drain();
                    mon.end_test(v0);
                end
                default: begin
                    $display("Unknown command '%c' in the pattern file", c);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("summary: %0d tests, %0d errors, %0d assertion failures",
                 mon.tests, mon.errors, dut.chk.fails);
        if (!aborted && mon.errors == 0 && dut.chk.fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/rob_pkg.sv
verilog/dispatch_port.sv
verilog/rob_buffer.sv
verilog/reg_status.sv
verilog/rob_core_top.sv
sim/rob_monitor.sv
sim/rob_checker.sv
sim/rob_tb.sv

/* verilog/dispatch_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module dispatch_port
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_req,
    input  dispatch_t         disp,
    output logic              disp_ack,
    output logic [`TAG_W-1:0] disp_tag,
    input  logic              alloc_ready,
    input  logic [`TAG_W-1:0] tail_tag,
    output logic              alloc,
    output dispatch_t         alloc_entry
);

    disp_state_e state;
    disp_state_e state_next;

    // one allocation per four-phase transaction
    assign alloc       = (state == st_idle) && disp_req && alloc_ready;
    assign alloc_entry = disp;
    assign disp_ack    = (state == st_grant);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (alloc) begin
                    state_next = st_grant;
                end
            end
            st_grant: begin
                // hold ack until the decoder lets go of req
                if (!disp_req) begin
                    state_next = st_release;
                end
            end
            st_release: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            disp_tag <= tail_tag;
        end
    end

endmodule

`default_nettype wire

/* verilog/reg_status.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module reg_status
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  dispatch_t         alloc_entry,
    input  logic [`TAG_W-1:0] tail_tag,
    input  logic [`REG_W-1:0] q_rs1,
    input  logic [`REG_W-1:0] q_rs2,
    output operand_t          q_op1,
    output operand_t          q_op2,
    output logic [`TAG_W-1:0] look_tag1,
    output logic [`TAG_W-1:0] look_tag2,
    input  operand_t          look_res1,
    input  operand_t          look_res2,
    input  commit_t           commit,
    input  logic              flush
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic [`TAG_W-1:0]  rtag [`NUM_REGS];

    function automatic logic writes_reg(input rob_op_e op);
        return (op == op_alu) || (op == op_load) || (op == op_jalr);
    endfunction

    function automatic operand_t resolve(input logic [`TAG_W-1:0]  t,
                                         input logic [`DATA_W-1:0] committed,
                                         input operand_t           fwd);
        operand_t res;
        if (t == '0) begin
            res.ready = 1'b1;
            res.value = committed;
            res.tag   = '0;
        end else begin
            res.ready = fwd.ready;
            res.value = fwd.value;
            res.tag   = fwd.tag;
        end
        return res;
    endfunction

    // x0 is never renamed nor written, so it always reads ready zero
    assign look_tag1 = rtag[q_rs1];
    assign look_tag2 = rtag[q_rs2];

    assign q_op1 = resolve(look_tag1, regs[q_rs1], look_res1);
    assign q_op2 = resolve(look_tag2, regs[q_rs2], look_res2);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
                rtag[r] <= '0;
            end
        end else begin
            if (commit.valid && writes_reg(commit.op) && commit.dest != '0) begin
                regs[commit.dest] <= commit.value;
                // a younger writer keeps its rename
                if (rtag[commit.dest] == commit.tag) begin
                    rtag[commit.dest] <= '0;
                end
            end
            if (flush) begin
                for (int r = 0; r < `NUM_REGS; r++) begin
                    rtag[r] <= '0;
                end
            end
            // rename last, so it wins over a clear at the same edge
            if (alloc && writes_reg(alloc_entry.op) && alloc_entry.dest != '0) begin
                rtag[alloc_entry.dest] <= tail_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rob_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_buffer
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  dispatch_t         alloc_entry,
    output logic              alloc_ready,
    output logic [`TAG_W-1:0] tail_tag,
    input  cdb_t              alu_cdb,
    input  cdb_t              ls_cdb,
    input  logic [`TAG_W-1:0] look_tag1,
    input  logic [`TAG_W-1:0] look_tag2,
    output operand_t          look_res1,
    output operand_t          look_res2,
    output commit_t           commit,
    output redirect_t         redirect,
    output logic              flush
);

    // per-tag storage without a slot for tag 0
    dispatch_t          entry  [1:`ROB_DEPTH];
    logic               ready  [1:`ROB_DEPTH];
    logic [`DATA_W-1:0] value  [1:`ROB_DEPTH];
    logic               taken  [1:`ROB_DEPTH];
    logic [`DATA_W-1:0] target [1:`ROB_DEPTH];

    logic [`TAG_W-1:0]  head;
    logic [`TAG_W-1:0]  tail;
    logic [`TAG_W-1:0]  count;

    dispatch_t          head_entry;
    logic               head_go;
    logic               head_redirect;
    logic [`DATA_W-1:0] head_pc;

    function automatic logic [`TAG_W-1:0] next_tag(input logic [`TAG_W-1:0] t);
        return (t == `TAG_W'(`ROB_DEPTH)) ? `TAG_W'(1) : t + `TAG_W'(1);
    endfunction

    function automatic operand_t lookup(input logic [`TAG_W-1:0] t);
        operand_t res;
        res.ready = 1'b0;
        res.value = '0;
        res.tag   = t;
        if (t != '0 && t <= `TAG_W'(`ROB_DEPTH)) begin
            res.ready = ready[t];
            res.value = value[t];
        end
        return res;
    endfunction

    // ready bits survive commit so a retiring value stays visible
    // until reg_status has taken it
    always_comb begin
        look_res1 = lookup(look_tag1);
        look_res2 = lookup(look_tag2);
    end

    assign head_entry = entry[head];
    assign head_go    = (count != '0) && ready[head];

    always_comb begin
        head_redirect = 1'b0;
        head_pc       = target[head];
        case (head_entry.op)
            op_branch: begin
                head_redirect = head_go && (taken[head] != head_entry.predicted_taken);
                if (!taken[head]) begin
                    head_pc = head_entry.pc + `DATA_W'(`PC_STEP);
                end
            end
            op_jalr: begin
                head_redirect = head_go;
            end
            default: begin
                head_redirect = 1'b0;
            end
        endcase
    end

    // no allocation while a redirect is made or is being flushed
    assign alloc_ready = (count != `TAG_W'(`ROB_DEPTH)) && !head_redirect && !flush;
    assign tail_tag    = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= `TAG_W'(1);
            tail     <= `TAG_W'(1);
            count    <= '0;
            commit   <= '0;
            redirect <= '0;
            flush    <= 1'b0;
            for (int i = 1; i <= `ROB_DEPTH; i++) begin
                ready[i] <= 1'b0;
            end
        end else begin
            if (alloc) begin
                ready[tail] <= 1'b0;
            end
            if (alu_cdb.valid) begin
                ready[alu_cdb.tag] <= 1'b1;
            end
            if (ls_cdb.valid) begin
                ready[ls_cdb.tag] <= 1'b1;
            end

            commit.valid <= head_go;
            commit.op    <= head_entry.op;
            commit.dest  <= head_entry.dest;
            commit.tag   <= head;
            commit.value <= value[head];

            redirect.valid <= head_redirect;
            redirect.pc    <= head_pc;
            flush          <= head_redirect;

            if (head_redirect) begin
                // drop everything younger than the retiring entry
                head  <= next_tag(head);
                tail  <= next_tag(head);
                count <= '0;
            end else begin
                if (head_go) begin
                    head <= next_tag(head);
                end
                if (alloc) begin
                    tail <= next_tag(tail);
                end
                count <= count + `TAG_W'(alloc) - `TAG_W'(head_go);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry[tail] <= alloc_entry;
        end
        if (alu_cdb.valid) begin
            value[alu_cdb.tag]  <= alu_cdb.value;
            taken[alu_cdb.tag]  <= alu_cdb.taken;
            target[alu_cdb.tag] <= alu_cdb.target;
        end
        if (ls_cdb.valid) begin
            value[ls_cdb.tag]  <= ls_cdb.value;
            taken[ls_cdb.tag]  <= ls_cdb.taken;
            target[ls_cdb.tag] <= ls_cdb.target;
        end
    end

endmodule

`default_nettype wire

/* verilog/rob_consts.svh */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer entries with tags 1..ROB_DEPTH
`define ROB_DEPTH 8

// tag 0 means no tag
`define TAG_W 4

// data and pc width
`define DATA_W 32

// register index width and architectural register count
`define REG_W 5
`define NUM_REGS 32

// fall-through pc increment
`define PC_STEP 4

`endif

/* verilog/rob_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_core_top
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_req,
    input  dispatch_t         disp,
    output logic              disp_ack,
    output logic [`TAG_W-1:0] disp_tag,
    input  cdb_t              alu_cdb,
    input  cdb_t              ls_cdb,
    input  logic [`REG_W-1:0] q_rs1,
    input  logic [`REG_W-1:0] q_rs2,
    output operand_t          q_op1,
    output operand_t          q_op2,
    output commit_t           commit_out,
    output redirect_t         redirect
);

    logic              alloc;
    dispatch_t         alloc_entry;
    logic              alloc_ready;
    logic [`TAG_W-1:0] tail_tag;
    logic [`TAG_W-1:0] look_tag1;
    logic [`TAG_W-1:0] look_tag2;
    operand_t          look_res1;
    operand_t          look_res2;
    logic              flush;

    dispatch_port u_dispatch_port (
        .clk         (clk),
        .rst         (rst),
        .disp_req    (disp_req),
        .disp        (disp),
        .disp_ack    (disp_ack),
        .disp_tag    (disp_tag),
        .alloc_ready (alloc_ready),
        .tail_tag    (tail_tag),
        .alloc       (alloc),
        .alloc_entry (alloc_entry)
    );

    rob_buffer u_rob_buffer (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .alloc_entry (alloc_entry),
        .alloc_ready (alloc_ready),
        .tail_tag    (tail_tag),
        .alu_cdb     (alu_cdb),
        .ls_cdb      (ls_cdb),
        .look_tag1   (look_tag1),
        .look_tag2   (look_tag2),
        .look_res1   (look_res1),
        .look_res2   (look_res2),
        .commit      (commit_out),
        .redirect    (redirect),
        .flush       (flush)
    );

    reg_status u_reg_status (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .alloc_entry (alloc_entry),
        .tail_tag    (tail_tag),
        .q_rs1       (q_rs1),
        .q_rs2       (q_rs2),
        .q_op1       (q_op1),
        .q_op2       (q_op2),
        .look_tag1   (look_tag1),
        .look_tag2   (look_tag2),
        .look_res1   (look_res1),
        .look_res2   (look_res2),
        .commit      (commit_out),
        .flush       (flush)
    );

endmodule

`default_nettype wire

/* verilog/rob_pkg.sv */
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jalr
    } rob_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_grant,
        st_release
    } disp_state_e;

    typedef struct packed {
        rob_op_e             op;
        logic [`REG_W-1:0]   dest;
        logic [`DATA_W-1:0]  pc;
        logic                predicted_taken;
    } dispatch_t;

    // taken and target stay zero on the load/store bus
    typedef struct packed {
        logic                valid;
        logic [`TAG_W-1:0]   tag;
        logic [`DATA_W-1:0]  value;
        logic                taken;
        logic [`DATA_W-1:0]  target;
    } cdb_t;

    typedef struct packed {
        logic                valid;
        rob_op_e             op;
        logic [`REG_W-1:0]   dest;
        logic [`TAG_W-1:0]   tag;
        logic [`DATA_W-1:0]  value;
    } commit_t;

    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
    } redirect_t;

    typedef struct packed {
        logic                ready;
        logic [`DATA_W-1:0]  value;
        logic [`TAG_W-1:0]   tag;
    } operand_t;

endpackage

`default_nettype wire
